// ==== dv/periph_vectors.txt ====
# ops W addr data, R addr expect, G gpi, I bit, U byte, O gpo, X ext_int, M addr max; hex
# a line that starts with # begins a new test group named by the rest of the line
# register map and window
W f3 a5
W f4 3c
O 3ca5
R f3 a5
R f4 3c
W f0 ff
R f0 00
W fe 77
R fe 00
W ff 77
R ff 00
W ed 55
R ed 00
W 00 55
R 00 00
O 3ca5
R ee 00
# gpio inputs and edge interrupts
W f5 0f
W f6 80
W ee 01
G 8015
R f1 15
R f2 80
I 0
R f7 05
R f8 80
R ef 01
W f7 01
R f7 04
G 0000
R f1 00
R f8 80
W f7 04
W f8 80
R f7 00
R f8 00
W ef 01
R ef 00
# timer compare
W fa 06
W f9 02
W ee 02
W f9 01
I 1
W f9 00
M fb 06
R f9 00
R fa 06
R ef 02
W ef 02
R ef 00
# uart frame
W ee 04
W fc 5a
R fd 01
U 5a
W fc c3
I 2
R fd 00
R ef 04
W ef 04
R ef 00
# interrupt controller rules
W ee 00
G 0001
W fc 3c
X 0
R ef 01
U 3c
W ee 04
I 2
W ee 01
X 9
R ef 05
W ee 05
X d
W ef 01
R ef 04
X c
W ef 04
R ef 00
X 0

// ==== src.f ====
logic/periph_cfg_pkg.sv
logic/periph_map_pkg.sv
logic/periph_bus_if.sv
logic/reflet_exti.sv
logic/reflet_gpio.sv
logic/reflet_timer.sv
logic/reflet_uart.sv
logic/reflet_peripheral_minimal.sv
dv/tb_periph.sv

// ==== run_sim.sh ====
#!/bin/sh
# Builds the hub testbench with Verilator, runs it and fails when the log reports failure.
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f src.f --top-module tb_periph -o tb_periph
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_periph > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "sim failed" "$log"; then
    exit 1
fi
exit 0

// ==== dv/tb_periph.sv ====
// Testbench for the peripheral hub; replays the bus vector file and checks reads, pins and frames.
`timescale 1ns/1ps

module tb_periph;

    localparam int cyc_limit = 2000; // Longest any single wait may take, in cycles.
    localparam int half_bit = periph_cfg_pkg::uart_divisor / 2;
    localparam int gpi_settle = 3;   // Input register, edge flag, then the pending bit.

    logic                              clk;
    logic                              rst_n;
    logic                              enable;
    logic [periph_cfg_pkg::word_w-1:0] addr;
    logic [periph_cfg_pkg::word_w-1:0] data_in;
    logic                              write_en;
    logic [periph_cfg_pkg::gpio_w-1:0] gpi;
    logic                              rx;
    logic [3:0]                        ext_int;
    logic [periph_cfg_pkg::word_w-1:0] data_out;
    logic [periph_cfg_pkg::gpio_w-1:0] gpo;
    logic                              tx;

    int    errors = 0;
    int    ops_in_group = 0;
    int    groups_passed = 0;
    int    groups_failed = 0;
    string group_name;

    int    neg_cnt = 0;
    int    fall_at = 0;
    int    fall_num = 0;
    int    frame_end = 0;
    int    frames_taken = 0;
    logic  tx_last = 1'b1;

    initial
    begin
        clk = 1'b0;
        forever
            #4 clk = ~clk;
    end

    reflet_peripheral_minimal dut (
        .clk(clk),
        .rst_n(rst_n),
        .enable(enable),
        .addr(addr),
        .data_in(data_in),
        .write_en(write_en),
        .gpi(gpi),
        .rx(rx),
        .ext_int(ext_int),
        .data_out(data_out),
        .gpo(gpo),
        .tx(tx)
    );

    // Falling edges inside a frame are data bits, so only one per frame is taken as a start.
    always @(negedge clk)
    begin
        neg_cnt <= neg_cnt + 1;
        tx_last <= tx;
        if (tx_last === 1'b1 && tx === 1'b0 && neg_cnt >= frame_end)
        begin
            fall_at <= neg_cnt;
            fall_num <= fall_num + 1;
            frame_end <= neg_cnt + 9 * periph_cfg_pkg::uart_divisor + half_bit;
        end
    end

    task automatic note_failure(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    task automatic close_group();
        if (errors == 0)
        begin
            groups_passed++;
            $display("PASS %s", group_name);
        end
        else
        begin
            groups_failed++;
            $display("FAIL %s with %0d errors", group_name, errors);
        end
        errors = 0;
        ops_in_group = 0;
    endtask

    function automatic string strip_text(input string s);
        int first;
        int last;
        first = 0;
        last = s.len() - 1;
        while (first <= last && (s[first] == " " || s[first] == "#"))
        begin
            first++;
        end
        while (last >= first && (s[last] == "\n" || s[last] == "\r" || s[last] == " "))
        begin
            last--;
        end
        return s.substr(first, last);
    endfunction

    task automatic idle_gap();
        int n;
        n = $urandom_range(3, 0);
        repeat (n)
        begin
            @(posedge clk);
            enable <= 1'b0;
        end
    endtask

    task automatic bus_write(input logic [7:0] a, input logic [7:0] d);
        @(posedge clk);
        enable <= 1'b1;
        write_en <= 1'b1;
        addr <= a;
        data_in <= d;
        @(posedge clk); // The DUT captures the write on this edge.
        enable <= 1'b0;
        write_en <= 1'b0;
    endtask

    task automatic bus_read(input logic [7:0] a, output logic [7:0] v);
        @(posedge clk);
        enable <= 1'b1;
        write_en <= 1'b0;
        addr <= a;
        @(negedge clk);
        v = data_out;
    endtask

    task automatic bus_read_check(input logic [7:0] a, input logic [7:0] expect_val);
        logic [7:0] got;
        bus_read(a, got);
        if (got !== expect_val)
        begin
            $display("ERROR data_out at addr %h expected %h got %h", a, expect_val, got);
            errors++;
        end
    endtask

    task automatic wait_ext_int(input int b);
        int waited;
        waited = 0;
        @(negedge clk);
        while (ext_int[b] !== 1'b1 && waited < cyc_limit)
        begin
            @(negedge clk);
            waited++;
        end
        if (ext_int[b] !== 1'b1)
            note_failure($sformatf("ext_int bit %0d never went high within the timeout", b));
    endtask

    task automatic receive_byte(input logic [7:0] expect_byte);
        int         waited;
        int         target;
        int         j;
        logic [9:0] frame;
        waited = 0;
        frame = '0;
        while (fall_num == frames_taken && waited < cyc_limit)
        begin
            @(negedge clk);
            waited++;
        end
        if (fall_num == frames_taken)
            note_failure("no start bit appeared on tx within the timeout");
        else
        begin
            frames_taken++;
            for (j = 0; j < 10; j++)
            begin
                target = fall_at + half_bit - 1 + j * periph_cfg_pkg::uart_divisor;
                if (neg_cnt > target)
                    note_failure("the middle of a serial bit passed before it was sampled");
                waited = 0;
                while (neg_cnt < target && waited < cyc_limit)
                begin
                    @(negedge clk);
                    waited++;
                end
                frame[j] = tx;
            end
            if (frame[0] !== 1'b0 || frame[9] !== 1'b1)
                note_failure("the serial frame had a bad start or stop bit");
            if (frame[8:1] !== expect_byte)
            begin
                $display("ERROR tx byte expected %h got %h", expect_byte, frame[8:1]);
                errors++;
            end
        end
    endtask

    task automatic check_stopped_count(input logic [7:0] a, input logic [7:0] limit);
        logic [7:0] first;
        logic [7:0] second;
        bus_read(a, first);
        repeat (4 * periph_cfg_pkg::timer_prescale) @(posedge clk);
        bus_read(a, second);
        if (first > limit)
        begin
            $display("ERROR tmr_cnt expected at most %h got %h", limit, first);
            errors++;
        end
        if (second !== first)
        begin
            $display("ERROR tmr_cnt expected %h got %h", first, second);
            errors++;
        end
    endtask

    task automatic run_vector(input logic [7:0] op, input int fd);
        logic [15:0] arg_a;
        logic [15:0] arg_b;
        int          code;
        arg_a = '0;
        arg_b = '0;
        case (op)
            "W", "R", "M": code = $fscanf(fd, "%h %h", arg_a, arg_b) - 1;
            default:       code = $fscanf(fd, "%h", arg_a);
        endcase
        if (code != 1)
            note_failure("a vector line has missing operands");
        case (op)
            "W": bus_write(arg_a[7:0], arg_b[7:0]);
            "R": bus_read_check(arg_a[7:0], arg_b[7:0]);
            "M": check_stopped_count(arg_a[7:0], arg_b[7:0]);
            "G":
            begin
                @(posedge clk);
                gpi <= arg_a;
                repeat (gpi_settle) @(posedge clk);
            end
            "I": wait_ext_int(int'(arg_a[1:0]));
            "U": receive_byte(arg_a[7:0]);
            "O":
            begin
                @(negedge clk);
                if (gpo !== arg_a)
                begin
                    $display("ERROR gpo expected %h got %h", arg_a, gpo);
                    errors++;
                end
            end
            "X":
            begin
                @(negedge clk);
                if (ext_int !== arg_a[3:0])
                begin
                    $display("ERROR ext_int expected %h got %h", arg_a[3:0], ext_int);
                    errors++;
                end
            end
            default: note_failure("the vector file holds an unknown opcode");
        endcase
    endtask

    initial
    begin
        int         fd;
        int         code;
        int         off;
        logic [7:0] op;
        string      line;
        rst_n <= 1'b0;
        enable <= 1'b0;
        addr <= '0;
        data_in <= '0;
        write_en <= 1'b0;
        gpi <= '0;
        rx <= 1'b1;
        void'($urandom(35));
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;

        group_name = "reset state";
        @(negedge clk);
        if (gpo !== '0)
        begin
            $display("ERROR gpo expected %h got %h", 16'h0000, gpo);
            errors++;
        end
        if (tx !== 1'b1)
        begin
            $display("ERROR tx expected %h got %h", 1'b1, tx);
            errors++;
        end
        if (ext_int !== 4'h0)
        begin
            $display("ERROR ext_int expected %h got %h", 4'h0, ext_int);
            errors++;
        end
        for (off = 0; off < int'(periph_map_pkg::window_size); off++)
            bus_read_check(periph_map_pkg::base_addr + 8'(off), 8'h00);
        close_group();

        fd = $fopen("dv/periph_vectors.txt", "r");
        if (fd == 0)
        begin
            group_name = "vector file";
            note_failure("the vector file dv/periph_vectors.txt could not be opened");
        end
        else
        begin
            code = $fscanf(fd, " %c", op);
            while (code == 1)
            begin
                if (op == "#")
                begin
                    if (ops_in_group > 0)
                        close_group();
                    code = $fgets(line, fd);
                    group_name = strip_text(line); // A comment line names the next group.
                end
                else
                begin
                    run_vector(op, fd);
                    ops_in_group++;
                    idle_gap();
                end
                code = $fscanf(fd, " %c", op);
            end
            $fclose(fd);
        end

        if (fall_num != frames_taken)
            note_failure("tx sent a serial frame that no vector expected");
        if (ops_in_group > 0 || errors > 0)
            close_group();
        $display("groups passed %0d failed %0d", groups_passed, groups_failed);
        if (groups_failed == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

// ==== logic/reflet_peripheral_minimal.sv ====
// Top level of the peripheral hub; decodes the bus window and joins the four peripheral blocks.
`timescale 1ns/1ps

module reflet_peripheral_minimal (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              enable,
    input  logic [periph_cfg_pkg::word_w-1:0] addr,
    input  logic [periph_cfg_pkg::word_w-1:0] data_in,
    input  logic                              write_en,
    input  logic [periph_cfg_pkg::gpio_w-1:0] gpi,
    input  logic                              rx,   // No receiver in this build.
    output logic [3:0]                        ext_int,
    output logic [periph_cfg_pkg::word_w-1:0] data_out,
    output logic [periph_cfg_pkg::gpio_w-1:0] gpo,
    output logic                              tx
);

    logic [periph_cfg_pkg::word_w-1:0] rel_addr;
    logic [periph_cfg_pkg::word_w-1:0] dout_exti;
    logic [periph_cfg_pkg::word_w-1:0] dout_gpio;
    logic [periph_cfg_pkg::word_w-1:0] dout_timer;
    logic [periph_cfg_pkg::word_w-1:0] dout_uart;
    logic                              int_gpio;
    logic                              int_timer;
    logic                              int_uart;

    periph_bus_if bus ();

    // Addresses below the base wrap to large values, so one compare bounds the window.
    assign rel_addr = addr - periph_map_pkg::base_addr;
    assign bus.sel = enable && rel_addr < periph_map_pkg::window_size;
    assign bus.offset = rel_addr[periph_cfg_pkg::offset_w-1:0];
    assign bus.wdata = data_in;
    assign bus.we = write_en;

    assign data_out = dout_exti | dout_gpio | dout_timer | dout_uart;

    reflet_exti exti (
        .clk(clk),
        .rst_n(rst_n),
        .bus(bus),
        .gpio_irq(int_gpio),
        .timer_irq(int_timer),
        .uart_irq(int_uart),
        .rdata(dout_exti),
        .ext_int(ext_int)
    );

    reflet_gpio gpio (
        .clk(clk),
        .rst_n(rst_n),
        .bus(bus),
        .gpi(gpi),
        .rdata(dout_gpio),
        .gpo(gpo),
        .irq(int_gpio)
    );

    reflet_timer timer (
        .clk(clk),
        .rst_n(rst_n),
        .bus(bus),
        .rdata(dout_timer),
        .irq(int_timer)
    );

    reflet_uart uart (
        .clk(clk),
        .rst_n(rst_n),
        .bus(bus),
        .rdata(dout_uart),
        .tx(tx),
        .irq(int_uart)
    );

endmodule

// ==== logic/reflet_uart.sv ====
// UART transmitter of the hub; sends 8N1 frames at a fixed divisor and reports busy and done.
`timescale 1ns/1ps

module reflet_uart (
    input  logic                              clk,
    input  logic                              rst_n,
    periph_bus_if.dev                         bus,
    output logic [periph_cfg_pkg::word_w-1:0] rdata,
    output logic                              tx,
    output logic                              irq
);

    logic [8:0]                               shreg; // Data bits, then the stop bit.
    logic [3:0]                               bit_cnt;
    logic [periph_cfg_pkg::uart_baud_w-1:0]   baud;
    logic                                     busy;
    logic                                     start;

    // Writes that arrive while a frame is running are dropped.
    assign start = bus.sel && bus.we && bus.offset == periph_map_pkg::uart_data && !busy;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            shreg <= '0;
            bit_cnt <= '0;
            baud <= '0;
            busy <= 1'b0;
            tx <= 1'b1;
            irq <= 1'b0;
        end
        else
        begin
            irq <= 1'b0;
            if (start)
            begin
                shreg <= {1'b1, bus.wdata};
                bit_cnt <= '0;
                baud <= '0;
                busy <= 1'b1;
                tx <= 1'b0; // Start bit.
            end
            else if (busy)
            begin
                if (baud == periph_cfg_pkg::uart_baud_last)
                begin
                    baud <= '0;
                    if (bit_cnt == 4'd9)
                    begin
                        busy <= 1'b0; // Stop bit has run its full length.
                        tx <= 1'b1;
                        irq <= 1'b1;
                    end
                    else
                    begin
                        tx <= shreg[0];
                        shreg <= {1'b1, shreg[8:1]};
                        bit_cnt <= bit_cnt + 1'b1;
                    end
                end
                else
                    baud <= baud + 1'b1;
            end
        end
    end

    // The receive side is not built, so uart_data reads back as zero.
    always_comb
    begin
        rdata = '0;
        if (bus.sel && bus.offset == periph_map_pkg::uart_status)
            rdata = {7'b0000000, busy};
    end

    a_idle_high: assert property (@(posedge clk) disable iff (!rst_n) !busy |-> tx);

endmodule

// ==== logic/reflet_timer.sv ====
// Timer block of the hub; a prescaled up-counter that wraps on compare match and pulses irq.
`timescale 1ns/1ps

module reflet_timer (
    input  logic                              clk,
    input  logic                              rst_n,
    periph_bus_if.dev                         bus,
    output logic [periph_cfg_pkg::word_w-1:0] rdata,
    output logic                              irq
);

    periph_cfg_pkg::timer_ctrl_u                ctrl;
    periph_cfg_pkg::timer_ctrl_u                wr_ctrl;
    logic [periph_cfg_pkg::timer_presc_w-1:0]   presc;
    logic [periph_cfg_pkg::word_w-1:0]          cmp;
    logic [periph_cfg_pkg::word_w-1:0]          cnt;
    logic                                       ctrl_wr;
    logic                                       clear_req;

    always_comb
    begin
        wr_ctrl.raw = bus.wdata; // Same byte, seen through the field view.
    end

    assign ctrl_wr = bus.sel && bus.we && bus.offset == periph_map_pkg::tmr_ctrl;
    assign clear_req = ctrl_wr && wr_ctrl.f.clear;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            ctrl.raw <= '0;
            cmp <= '0;
            cnt <= '0;
            presc <= '0;
            irq <= 1'b0;
        end
        else
        begin
            irq <= 1'b0;
            if (ctrl_wr)
            begin
                ctrl.raw <= bus.wdata;
                ctrl.f.clear <= 1'b0; // Clear acts once and always reads back zero.
            end
            if (bus.sel && bus.we && bus.offset == periph_map_pkg::tmr_cmp)
                cmp <= bus.wdata;

            if (clear_req)
            begin
                cnt <= '0;
                presc <= '0;
            end
            else if (ctrl.f.run)
            begin
                if (presc == periph_cfg_pkg::timer_presc_last)
                begin
                    presc <= '0;
                    if (cnt == cmp)
                    begin
                        cnt <= '0;
                        irq <= 1'b1;
                    end
                    else
                        cnt <= cnt + 1'b1;
                end
                else
                    presc <= presc + 1'b1;
            end
        end
    end

    always_comb
    begin
        rdata = '0;
        if (bus.sel && bus.offset == periph_map_pkg::tmr_ctrl)
            rdata = ctrl.raw;
        else if (bus.sel && bus.offset == periph_map_pkg::tmr_cmp)
            rdata = cmp;
        else if (bus.sel && bus.offset == periph_map_pkg::tmr_cnt)
            rdata = cnt;
    end

    a_irq_single: assert property (@(posedge clk) disable iff (!rst_n) irq |=> !irq);

endmodule

// ==== logic/reflet_gpio.sv ====
// GPIO block of the hub; samples inputs, flags enabled rising edges and holds output latches.
`timescale 1ns/1ps

module reflet_gpio (
    input  logic                              clk,
    input  logic                              rst_n,
    periph_bus_if.dev                         bus,
    input  logic [periph_cfg_pkg::gpio_w-1:0] gpi,
    output logic [periph_cfg_pkg::word_w-1:0] rdata,
    output logic [periph_cfg_pkg::gpio_w-1:0] gpo,
    output logic                              irq
);

    logic [periph_cfg_pkg::gpio_w-1:0] gpi_q;
    logic [periph_cfg_pkg::gpio_w-1:0] gpi_prev;
    logic [periph_cfg_pkg::gpio_w-1:0] ie;
    logic [periph_cfg_pkg::gpio_w-1:0] flag;
    logic [periph_cfg_pkg::gpio_w-1:0] rise;
    logic [periph_cfg_pkg::gpio_w-1:0] flag_clr;
    logic                              wr;

    assign wr = bus.sel && bus.we;
    assign rise = gpi_q & ~gpi_prev & ie;

    always_comb
    begin
        flag_clr = '0;
        if (wr && bus.offset == periph_map_pkg::gpio_flag_lo)
            flag_clr[7:0] = bus.wdata;
        if (wr && bus.offset == periph_map_pkg::gpio_flag_hi)
            flag_clr[15:8] = bus.wdata;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            gpi_q <= '0;
            gpi_prev <= '0;
            ie <= '0;
            flag <= '0;
            gpo <= '0;
            irq <= 1'b0;
        end
        else
        begin
            gpi_q <= gpi;
            gpi_prev <= gpi_q;
            flag <= (flag & ~flag_clr) | rise;
            irq <= |(rise & ~flag); // Only on a flag that was not already set.
            if (wr)
            begin
                case (bus.offset)
                    periph_map_pkg::gpio_out_lo: gpo[7:0] <= bus.wdata;
                    periph_map_pkg::gpio_out_hi: gpo[15:8] <= bus.wdata;
                    periph_map_pkg::gpio_ie_lo:  ie[7:0] <= bus.wdata;
                    periph_map_pkg::gpio_ie_hi:  ie[15:8] <= bus.wdata;
                    default: ;
                endcase
            end
        end
    end

    always_comb
    begin
        rdata = '0;
        if (bus.sel)
        begin
            case (bus.offset)
                periph_map_pkg::gpio_in_lo:   rdata = gpi_q[7:0];
                periph_map_pkg::gpio_in_hi:   rdata = gpi_q[15:8];
                periph_map_pkg::gpio_out_lo:  rdata = gpo[7:0];
                periph_map_pkg::gpio_out_hi:  rdata = gpo[15:8];
                periph_map_pkg::gpio_ie_lo:   rdata = ie[7:0];
                periph_map_pkg::gpio_ie_hi:   rdata = ie[15:8];
                periph_map_pkg::gpio_flag_lo: rdata = flag[7:0];
                periph_map_pkg::gpio_flag_hi: rdata = flag[15:8];
                default:                      rdata = '0;
            endcase
        end
    end

    a_flag_needs_ie: assert property (@(posedge clk) disable iff (!rst_n)
        (flag & ~$past(flag) & ~$past(ie)) == '0);

endmodule

// ==== logic/reflet_exti.sv ====
// Interrupt controller of the hub; latches source pulses and drives the masked CPU lines.
`timescale 1ns/1ps

module reflet_exti (
    input  logic                              clk,
    input  logic                              rst_n,
    periph_bus_if.dev                         bus,
    input  logic                              gpio_irq,
    input  logic                              timer_irq,
    input  logic                              uart_irq,
    output logic [periph_cfg_pkg::word_w-1:0] rdata,
    output logic [3:0]                        ext_int
);

    logic [2:0] mask;
    logic [2:0] pend;
    logic [2:0] src;
    logic [2:0] pend_clr;
    logic       mask_wr;

    always_comb
    begin
        src = '0;
        src[periph_cfg_pkg::irq_gpio] = gpio_irq;
        src[periph_cfg_pkg::irq_timer] = timer_irq;
        src[periph_cfg_pkg::irq_uart] = uart_irq;
    end

    assign mask_wr = bus.sel && bus.we && bus.offset == periph_map_pkg::exti_mask;
    assign pend_clr = (bus.sel && bus.we && bus.offset == periph_map_pkg::exti_pend)
                    ? bus.wdata[2:0] : 3'b000;

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            mask <= '0;
            pend <= '0;
        end
        else
        begin
            pend <= (pend & ~pend_clr) | src; // A new pulse beats a clear.
            if (mask_wr)
                mask <= bus.wdata[2:0];
        end
    end

    assign ext_int[2:0] = pend & mask;
    assign ext_int[3] = |(pend & mask);

    always_comb
    begin
        rdata = '0;
        if (bus.sel && bus.offset == periph_map_pkg::exti_mask)
            rdata = {5'b00000, mask};
        else if (bus.sel && bus.offset == periph_map_pkg::exti_pend)
            rdata = {5'b00000, pend};
    end

    // An unmasked pulse reaches the summary line on the next cycle, even against a clear.
    a_pulse_wins: assert property (@(posedge clk) disable iff (!rst_n)
        ((src & mask) != '0 && !mask_wr) |=> ext_int[3]);

    // A pending bit only ever comes from a pulse of its own source.
    a_pend_from_src: assert property (@(posedge clk) disable iff (!rst_n)
        (pend & ~$past(pend) & ~$past(src)) == '0);

endmodule

// ==== logic/periph_bus_if.sv ====
// Decoded bus request that the hub top fans out to every peripheral block.
`timescale 1ns/1ps

interface periph_bus_if;

    logic                                 sel;    // Address falls inside the window.
    logic [periph_cfg_pkg::offset_w-1:0]  offset; // Address relative to the window base.
    logic [periph_cfg_pkg::word_w-1:0]    wdata;
    logic                                 we;

    modport host (
        output sel,
        output offset,
        output wdata,
        output we
    );

    modport dev (
        input sel,
        input offset,
        input wdata,
        input we
    );

endinterface

// ==== logic/periph_map_pkg.sv ====
// Register map of the hub: bus window placement and the offset of every peripheral register.
package periph_map_pkg;

    localparam logic [periph_cfg_pkg::word_w-1:0] base_addr = 8'hEE;
    localparam logic [periph_cfg_pkg::word_w-1:0] window_size = 8'd18;

    localparam logic [periph_cfg_pkg::offset_w-1:0] exti_mask = 5'd0;
    localparam logic [periph_cfg_pkg::offset_w-1:0] exti_pend = 5'd1;
    localparam logic [periph_cfg_pkg::offset_w-1:0] gpio_in_lo = 5'd3;
    localparam logic [periph_cfg_pkg::offset_w-1:0] gpio_in_hi = 5'd4;
    localparam logic [periph_cfg_pkg::offset_w-1:0] gpio_out_lo = 5'd5;
    localparam logic [periph_cfg_pkg::offset_w-1:0] gpio_out_hi = 5'd6;
    localparam logic [periph_cfg_pkg::offset_w-1:0] gpio_ie_lo = 5'd7;
    localparam logic [periph_cfg_pkg::offset_w-1:0] gpio_ie_hi = 5'd8;
    localparam logic [periph_cfg_pkg::offset_w-1:0] gpio_flag_lo = 5'd9;
    localparam logic [periph_cfg_pkg::offset_w-1:0] gpio_flag_hi = 5'd10;
    localparam logic [periph_cfg_pkg::offset_w-1:0] tmr_ctrl = 5'd11;
    localparam logic [periph_cfg_pkg::offset_w-1:0] tmr_cmp = 5'd12;
    localparam logic [periph_cfg_pkg::offset_w-1:0] tmr_cnt = 5'd13;
    localparam logic [periph_cfg_pkg::offset_w-1:0] uart_data = 5'd14;
    localparam logic [periph_cfg_pkg::offset_w-1:0] uart_status = 5'd15;

endpackage

// ==== logic/periph_cfg_pkg.sv ====
// Widths, clock and baud constants, interrupt indices and the timer control type for the hub.
package periph_cfg_pkg;

    localparam int word_w = 8;
    localparam int offset_w = 5;
    localparam int gpio_w = 16;

    localparam int timer_prescale = 4; // Clock cycles per timer tick.
    localparam int uart_divisor = 16;  // Clock cycles per serial bit.

    localparam int timer_presc_w = $clog2(timer_prescale);
    localparam logic [timer_presc_w-1:0] timer_presc_last = timer_presc_w'(timer_prescale - 1);
    localparam int uart_baud_w = $clog2(uart_divisor);
    localparam logic [uart_baud_w-1:0] uart_baud_last = uart_baud_w'(uart_divisor - 1);

    // Bit positions of the interrupt sources in the pending and mask registers.
    localparam int irq_gpio = 0;
    localparam int irq_timer = 1;
    localparam int irq_uart = 2;

    typedef struct packed {
        logic [5:0] spare;
        logic       clear; // Zeroes the counter, never stored.
        logic       run;
    } timer_ctrl_t;

    typedef union packed {
        logic [word_w-1:0] raw;
        timer_ctrl_t       f;
    } timer_ctrl_u;

endpackage
